// File: fpnc_cfg.svh
// ----------------------------------------------------------------------
// Build-time configuration of the binary32 non-computational FPU
// Include wherever the format widths, tag width or stage count are needed
// ----------------------------------------------------------------------

`ifndef FPNC_CFG_SVH
`define FPNC_CFG_SVH

// Exponent field width of binary32
`define FPNC_EXP_W 8

// Mantissa field width of binary32, hidden bit excluded
`define FPNC_MAN_W 23

// Width of the user tag carried along with each operation
`define FPNC_TAG_W 4

// Number of elastic register stages after the operation logic
// Zero gives a purely combinational unit
`define FPNC_NUM_STAGES 2

`endif

// File: fpnc_pkg.sv
// ----------------------------------------------------------------------
// Shared types and codes of the non-computational FPU
// Ports use scoped names, module bodies import the whole package
// ----------------------------------------------------------------------

`include "fpnc_cfg.svh"

package fpnc_pkg;

  // Format geometry
  localparam int unsigned EXP_W    = `FPNC_EXP_W;
  localparam int unsigned MAN_W    = `FPNC_MAN_W;
  localparam int unsigned FP_W     = 1 + EXP_W + MAN_W;
  localparam int unsigned SIGN_POS = FP_W - 1;
  localparam int unsigned TAG_W    = `FPNC_TAG_W;

  // Operand and result word, sign on top, then exponent, then mantissa
  typedef logic [FP_W-1:0]  fp_t;
  typedef logic [EXP_W-1:0] exp_t;
  typedef logic [MAN_W-1:0] man_t;

  // Operation group
  typedef logic [1:0] op_t;
  localparam op_t OP_SGNJ     = 2'd0;
  localparam op_t OP_MINMAX   = 2'd1;
  localparam op_t OP_CMP      = 2'd2;
  localparam op_t OP_CLASSIFY = 2'd3;

  // Sub-operation selector, travels in the rounding-mode field
  typedef logic [2:0] rm_t;
  localparam rm_t RM_RNE = 3'b000;
  localparam rm_t RM_RTZ = 3'b001;
  localparam rm_t RM_RDN = 3'b010;
  localparam rm_t RM_RUP = 3'b011;

  // Exception flags and their bit positions
  typedef logic [4:0] status_t;
  localparam int unsigned STATUS_NV = 4;
  localparam int unsigned STATUS_DZ = 3;
  localparam int unsigned STATUS_OF = 2;
  localparam int unsigned STATUS_UF = 1;
  localparam int unsigned STATUS_NX = 0;

  // One-hot classification result, each code has its single bit set
  typedef logic [9:0] class_mask_t;
  localparam class_mask_t NEGINF     = 10'b00_0000_0001;
  localparam class_mask_t NEGNORM    = 10'b00_0000_0010;
  localparam class_mask_t NEGSUBNORM = 10'b00_0000_0100;
  localparam class_mask_t NEGZERO    = 10'b00_0000_1000;
  localparam class_mask_t POSZERO    = 10'b00_0001_0000;
  localparam class_mask_t POSSUBNORM = 10'b00_0010_0000;
  localparam class_mask_t POSNORM    = 10'b00_0100_0000;
  localparam class_mask_t POSINF     = 10'b00_1000_0000;
  localparam class_mask_t SNAN       = 10'b01_0000_0000;
  localparam class_mask_t QNAN       = 10'b10_0000_0000;

  // User tag
  typedef logic [TAG_W-1:0] tag_t;

  // Canonical quiet NaN, positive with only the quiet bit set
  localparam fp_t CANON_NAN = {1'b0, {EXP_W{1'b1}}, 1'b1, {(MAN_W-1){1'b0}}};

endpackage

// File: fpnc_classifier.sv
// ----------------------------------------------------------------------
// Operand classifier, splits one binary32 value into exclusive categories
// ----------------------------------------------------------------------

module fpnc_classifier (
  input  fpnc_pkg::fp_t operand_i,
  output logic          is_zero_o,
  output logic          is_subnormal_o,
  output logic          is_normal_o,
  output logic          is_inf_o,
  output logic          is_nan_o,
  output logic          is_signalling_o
);

  import fpnc_pkg::*;

  exp_t exponent;
  man_t mantissa;
  logic exp_zero;
  logic exp_ones;
  logic man_zero;

  // Field extraction
  assign exponent = operand_i[SIGN_POS-1 -: EXP_W];
  assign mantissa = operand_i[MAN_W-1:0];

  // Exponent extremes and empty mantissa
  assign exp_zero = (exponent == '0);
  assign exp_ones = (exponent == '1);
  assign man_zero = (mantissa == '0);

  // Zero exponent splits into true zero and denormals
  assign is_zero_o      = exp_zero & man_zero;
  assign is_subnormal_o = exp_zero & ~man_zero;

  // Anything between the two exponent extremes
  assign is_normal_o    = ~exp_zero & ~exp_ones;

  // Saturated exponent gives infinity or NaN
  assign is_inf_o       = exp_ones & man_zero;
  assign is_nan_o       = exp_ones & ~man_zero;

  // Quiet bit clear marks a signalling NaN
  assign is_signalling_o = is_nan_o & ~mantissa[MAN_W-1];

endmodule

// File: fpnc_ops.sv
// ----------------------------------------------------------------------
// Combinational core, computes sign injection, min/max, compare and class
// and selects one result by the operation group
// ----------------------------------------------------------------------

module fpnc_ops (
  input  fpnc_pkg::fp_t         operand_a_i,
  input  fpnc_pkg::fp_t         operand_b_i,
  input  fpnc_pkg::op_t         op_i,
  input  fpnc_pkg::rm_t         rm_i,
  input  logic                  op_mod_i,
  output fpnc_pkg::fp_t         result_o,
  output fpnc_pkg::status_t     status_o,
  output fpnc_pkg::class_mask_t class_mask_o,
  output logic                  is_class_o
);

  import fpnc_pkg::*;

  // --------------------------------------------------------------------
  // Operand classification
  // --------------------------------------------------------------------
  logic a_zero, a_subnormal, a_normal, a_inf, a_nan, a_snan;
  logic b_zero, b_nan, b_snan;

  fpnc_classifier u_class_a (
    .operand_i       (operand_a_i),
    .is_zero_o       (a_zero),
    .is_subnormal_o  (a_subnormal),
    .is_normal_o     (a_normal),
    .is_inf_o        (a_inf),
    .is_nan_o        (a_nan),
    .is_signalling_o (a_snan)
  );

  // Only zero and NaN information of b enters the result
  fpnc_classifier u_class_b (
    .operand_i       (operand_b_i),
    .is_zero_o       (b_zero),
    .is_subnormal_o  (),
    .is_normal_o     (),
    .is_inf_o        (),
    .is_nan_o        (b_nan),
    .is_signalling_o (b_snan)
  );

  logic sign_a, sign_b;
  logic any_nan, any_snan;
  logic operands_equal, a_smaller;

  assign sign_a   = operand_a_i[SIGN_POS];
  assign sign_b   = operand_b_i[SIGN_POS];
  assign any_nan  = a_nan | b_nan;
  assign any_snan = a_snan | b_snan;

  // Zeros are equal regardless of sign
  assign operands_equal = (operand_a_i == operand_b_i) || (a_zero && b_zero);

  // Unsigned compare flipped when a negative operand is involved
  // Gives sign-magnitude order with -0 below +0
  assign a_smaller = (operand_a_i < operand_b_i) ^ (sign_a | sign_b);

  // --------------------------------------------------------------------
  // Sign injection
  // --------------------------------------------------------------------
  fp_t sgnj_result;

  always_comb begin
    sgnj_result = operand_a_i;
    unique case (rm_i)
      // SGNJ
      RM_RNE: sgnj_result[SIGN_POS] = sign_b;
      // SGNJN
      RM_RTZ: sgnj_result[SIGN_POS] = ~sign_b;
      // SGNJX
      RM_RDN: sgnj_result[SIGN_POS] = sign_a ^ sign_b;
      // Passthrough of a
      RM_RUP: sgnj_result = operand_a_i;
      default: sgnj_result = operand_a_i;
    endcase
  end

  // --------------------------------------------------------------------
  // Minimum and maximum
  // --------------------------------------------------------------------
  fp_t     minmax_result;
  status_t minmax_status;

  always_comb begin
    // Quiet comparison, only signalling NaNs are invalid
    minmax_status            = '0;
    minmax_status[STATUS_NV] = any_snan;
    if (a_nan && b_nan) begin
      minmax_result = CANON_NAN;
    end else if (a_nan) begin
      minmax_result = operand_b_i;
    end else if (b_nan) begin
      minmax_result = operand_a_i;
    end else if (rm_i == RM_RTZ) begin
      // MAX
      minmax_result = a_smaller ? operand_b_i : operand_a_i;
    end else begin
      // MIN
      minmax_result = a_smaller ? operand_a_i : operand_b_i;
    end
  end

  // --------------------------------------------------------------------
  // Comparisons
  // --------------------------------------------------------------------
  fp_t     cmp_result;
  status_t cmp_status;

  always_comb begin
    cmp_result = '0;
    cmp_status = '0;
    if (any_snan) begin
      // Signalling NaN is false and invalid for every compare
      cmp_status[STATUS_NV] = 1'b1;
    end else begin
      unique case (rm_i)
        // LE, signalling on quiet NaN
        RM_RNE: begin
          if (any_nan) cmp_status[STATUS_NV] = 1'b1;
          else cmp_result[0] = (a_smaller | operands_equal) ^ op_mod_i;
        end
        // LT, signalling on quiet NaN
        RM_RTZ: begin
          if (any_nan) cmp_status[STATUS_NV] = 1'b1;
          else cmp_result[0] = (a_smaller & ~operands_equal) ^ op_mod_i;
        end
        // EQ, quiet NaN is simply unequal
        RM_RDN: begin
          if (any_nan) cmp_result[0] = op_mod_i;
          else cmp_result[0] = operands_equal ^ op_mod_i;
        end
        default: cmp_result = '0;
      endcase
    end
  end

  // --------------------------------------------------------------------
  // Classification of operand a
  // --------------------------------------------------------------------
  class_mask_t class_mask;

  always_comb begin
    if (a_normal) class_mask = sign_a ? NEGNORM : POSNORM;
    else if (a_subnormal) class_mask = sign_a ? NEGSUBNORM : POSSUBNORM;
    else if (a_zero) class_mask = sign_a ? NEGZERO : POSZERO;
    else if (a_inf) class_mask = sign_a ? NEGINF : POSINF;
    else if (a_snan) class_mask = SNAN;
    else class_mask = QNAN;
  end

  // --------------------------------------------------------------------
  // Result selection
  // --------------------------------------------------------------------
  always_comb begin
    result_o = '0;
    status_o = '0;
    unique case (op_i)
      OP_SGNJ: result_o = sgnj_result;
      OP_MINMAX: begin
        result_o = minmax_result;
        status_o = minmax_status;
      end
      OP_CMP: begin
        result_o = cmp_result;
        status_o = cmp_status;
      end
      // Mask goes out on its own port, result word stays zero
      OP_CLASSIFY: result_o = '0;
      default: result_o = '0;
    endcase
  end

  assign class_mask_o = class_mask;
  assign is_class_o   = (op_i == OP_CLASSIFY);

endmodule

// File: fpnc_pipe_stage.sv
// ----------------------------------------------------------------------
// Elastic register stage holding one item, valid/ready on both sides
// ----------------------------------------------------------------------

module fpnc_pipe_stage (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  flush_i,
  // Upstream side
  input  logic                  valid_i,
  output logic                  ready_o,
  input  fpnc_pkg::fp_t         result_i,
  input  fpnc_pkg::status_t     status_i,
  input  fpnc_pkg::class_mask_t class_mask_i,
  input  logic                  is_class_i,
  input  fpnc_pkg::tag_t        tag_i,
  // Downstream side
  output logic                  valid_o,
  input  logic                  ready_i,
  output fpnc_pkg::fp_t         result_o,
  output fpnc_pkg::status_t     status_o,
  output fpnc_pkg::class_mask_t class_mask_o,
  output logic                  is_class_o,
  output fpnc_pkg::tag_t        tag_o
);

  import fpnc_pkg::*;

  logic        valid_q;
  logic        load;
  fp_t         result_q;
  status_t     status_q;
  class_mask_t class_mask_q;
  logic        is_class_q;
  tag_t        tag_q;

  // Advance when downstream takes our item or we only hold a bubble
  assign ready_o = ready_i | ~valid_q;
  assign load    = ready_o & valid_i;

  // Valid bit, flush drops the held item and any incoming one
  always_ff @(posedge clk_i) begin
    if (rst_i || flush_i) begin
      valid_q <= 1'b0;
    end else if (ready_o) begin
      valid_q <= valid_i;
    end
  end

  // Payload only moves with a real item
  always_ff @(posedge clk_i) begin
    if (load) begin
      result_q     <= result_i;
      status_q     <= status_i;
      class_mask_q <= class_mask_i;
      is_class_q   <= is_class_i;
      tag_q        <= tag_i;
    end
  end

  assign valid_o      = valid_q;
  assign result_o     = result_q;
  assign status_o     = status_q;
  assign class_mask_o = class_mask_q;
  assign is_class_o   = is_class_q;
  assign tag_o        = tag_q;

endmodule

// File: fpnc_top.sv
// ----------------------------------------------------------------------
// Non-computational binary32 FPU, operation logic followed by a chain
// of elastic stages, valid/ready in and out with flush and busy
// ----------------------------------------------------------------------

`include "fpnc_cfg.svh"

module fpnc_top (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  flush_i,
  // Operation input
  input  fpnc_pkg::fp_t         operand_a_i,
  input  fpnc_pkg::fp_t         operand_b_i,
  input  fpnc_pkg::op_t         op_i,
  input  fpnc_pkg::rm_t         rm_i,
  input  logic                  op_mod_i,
  input  fpnc_pkg::tag_t        tag_i,
  input  logic                  in_valid_i,
  output logic                  in_ready_o,
  // Result output
  output fpnc_pkg::fp_t         result_o,
  output fpnc_pkg::status_t     status_o,
  output fpnc_pkg::class_mask_t class_mask_o,
  output logic                  is_class_o,
  output fpnc_pkg::tag_t        tag_o,
  output logic                  out_valid_o,
  input  logic                  out_ready_i,
  // Anything in flight or waiting at the input
  output logic                  busy_o
);

  import fpnc_pkg::*;

  localparam int unsigned NUM_STAGES = `FPNC_NUM_STAGES;

  // --------------------------------------------------------------------
  // Chain signals, index k is the value after k stages
  // --------------------------------------------------------------------
  logic [NUM_STAGES:0] pipe_valid;
  logic [NUM_STAGES:0] pipe_ready;
  fp_t                 pipe_result     [0:NUM_STAGES];
  status_t             pipe_status     [0:NUM_STAGES];
  class_mask_t         pipe_class_mask [0:NUM_STAGES];
  logic                pipe_is_class   [0:NUM_STAGES];
  tag_t                pipe_tag        [0:NUM_STAGES];

  // Operation logic feeds the head of the chain
  fpnc_ops u_ops (
    .operand_a_i  (operand_a_i),
    .operand_b_i  (operand_b_i),
    .op_i         (op_i),
    .rm_i         (rm_i),
    .op_mod_i     (op_mod_i),
    .result_o     (pipe_result[0]),
    .status_o     (pipe_status[0]),
    .class_mask_o (pipe_class_mask[0]),
    .is_class_o   (pipe_is_class[0])
  );

  // Valid and tag bypass the operation logic
  assign pipe_valid[0] = in_valid_i;
  assign pipe_tag[0]   = tag_i;
  assign in_ready_o    = pipe_ready[0];

  // --------------------------------------------------------------------
  // Elastic stages
  // --------------------------------------------------------------------
  for (genvar k = 0; k < NUM_STAGES; k++) begin : gen_stage
    fpnc_pipe_stage u_stage (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .flush_i      (flush_i),
      .valid_i      (pipe_valid[k]),
      .ready_o      (pipe_ready[k]),
      .result_i     (pipe_result[k]),
      .status_i     (pipe_status[k]),
      .class_mask_i (pipe_class_mask[k]),
      .is_class_i   (pipe_is_class[k]),
      .tag_i        (pipe_tag[k]),
      .valid_o      (pipe_valid[k+1]),
      .ready_i      (pipe_ready[k+1]),
      .result_o     (pipe_result[k+1]),
      .status_o     (pipe_status[k+1]),
      .class_mask_o (pipe_class_mask[k+1]),
      .is_class_o   (pipe_is_class[k+1]),
      .tag_o        (pipe_tag[k+1])
    );
  end

  // Tail of the chain drains straight to the ports
  assign pipe_ready[NUM_STAGES] = out_ready_i;
  assign out_valid_o            = pipe_valid[NUM_STAGES];
  assign result_o               = pipe_result[NUM_STAGES];
  assign status_o               = pipe_status[NUM_STAGES];
  assign class_mask_o           = pipe_class_mask[NUM_STAGES];
  assign is_class_o             = pipe_is_class[NUM_STAGES];
  assign tag_o                  = pipe_tag[NUM_STAGES];

  // Input valid plus every stage valid
  assign busy_o = |pipe_valid;

endmodule

// File: fpnc_properties.sv
// ----------------------------------------------------------------------
// Concurrent assertions on the FPU top level, attached by bind
// ----------------------------------------------------------------------

module fpnc_properties (
  input logic                  clk_i,
  input logic                  rst_i,
  input logic                  flush_i,
  input logic                  in_ready_o,
  input logic                  out_valid_o,
  input logic                  out_ready_i,
  input logic                  busy_o,
  input fpnc_pkg::fp_t         result_o,
  input fpnc_pkg::status_t     status_o,
  input fpnc_pkg::class_mask_t class_mask_o,
  input logic                  is_class_o,
  input fpnc_pkg::tag_t        tag_o
);
  timeunit 1ns;
  timeprecision 1ps;

  // Idle and ready right after a reset edge
  a_reset_idle: assert property (
    @(posedge clk_i) rst_i |=> !out_valid_o && !busy_o && in_ready_o
  ) else $error("outputs not idle after reset");

  // A stalled output item keeps its valid and its data
  a_stall_hold: assert property (
    @(posedge clk_i) disable iff (rst_i)
      out_valid_o && !out_ready_i && !flush_i |=>
        out_valid_o && $stable(result_o) && $stable(status_o) &&
        $stable(class_mask_o) && $stable(is_class_o) && $stable(tag_o)
  ) else $error("stalled output item changed or dropped");

  // Flush empties the pipeline
  a_flush_clears: assert property (
    @(posedge clk_i) disable iff (rst_i) flush_i |=> !out_valid_o
  ) else $error("output valid after flush");

endmodule

// File: fpnc_tb.sv
// ----------------------------------------------------------------------
// Directed testbench for the binary32 non-computational FPU
// Sends tagged items, checks every output against a reference model
// ----------------------------------------------------------------------

`include "fpnc_cfg.svh"

module fpnc_tb;
  timeunit 1ns;
  timeprecision 1ps;

  import fpnc_pkg::*;

  localparam int NUM_STAGES      = `FPNC_NUM_STAGES;
  localparam int CLK_PERIOD      = 10;
  localparam int TOTAL_ITEMS     = 200;
  localparam int WATCHDOG_CYCLES = TOTAL_ITEMS * (NUM_STAGES + 20) + 200;

  logic        clk_i, rst_i, flush_i;
  fp_t         operand_a_i, operand_b_i;
  op_t         op_i;
  rm_t         rm_i;
  logic        op_mod_i;
  tag_t        tag_i;
  logic        in_valid_i, in_ready_o;
  fp_t         result_o;
  status_t     status_o;
  class_mask_t class_mask_o;
  logic        is_class_o;
  tag_t        tag_o;
  logic        out_valid_o, out_ready_i, busy_o;

  // Bookkeeping
  int          error_count    = 0;
  int          items_sent     = 0;
  int          items_checked  = 0;
  int          tests_run      = 0;
  int          tests_failed   = 0;
  int          test_err_start = 0;
  logic [15:0] lfsr_state     = 16'd23930;
  tag_t        next_tag       = '0;
  logic        bp_mode        = 1'b0;
  logic        ready_level    = 1'b1;

  // Expected items in send order
  tag_t        exp_tag_q[$];
  fp_t         exp_result_q[$];
  status_t     exp_status_q[$];
  class_mask_t exp_mask_q[$];
  logic        exp_class_q[$];

  fpnc_top dut_i (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .flush_i      (flush_i),
    .operand_a_i  (operand_a_i),
    .operand_b_i  (operand_b_i),
    .op_i         (op_i),
    .rm_i         (rm_i),
    .op_mod_i     (op_mod_i),
    .tag_i        (tag_i),
    .in_valid_i   (in_valid_i),
    .in_ready_o   (in_ready_o),
    .result_o     (result_o),
    .status_o     (status_o),
    .class_mask_o (class_mask_o),
    .is_class_o   (is_class_o),
    .tag_o        (tag_o),
    .out_valid_o  (out_valid_o),
    .out_ready_i  (out_ready_i),
    .busy_o       (busy_o)
  );

  bind fpnc_top fpnc_properties u_properties (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .flush_i      (flush_i),
    .in_ready_o   (in_ready_o),
    .out_valid_o  (out_valid_o),
    .out_ready_i  (out_ready_i),
    .busy_o       (busy_o),
    .result_o     (result_o),
    .status_o     (status_o),
    .class_mask_o (class_mask_o),
    .is_class_o   (is_class_o),
    .tag_o        (tag_o)
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  // ----------------------------------------------------------------------
  // Random source, 16-bit Galois LFSR stepped once per bit
  // ----------------------------------------------------------------------
  function automatic logic random_bit();
    logic bit_out;
    bit_out    = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (bit_out) lfsr_state = lfsr_state ^ 16'hb400;
    return bit_out;
  endfunction

  function automatic fp_t random_operand();
    fp_t        w;
    logic [2:0] kind;
    for (int i = 0; i < FP_W; i++) begin
      w[i] = random_bit();
    end
    kind[0] = random_bit();
    kind[1] = random_bit();
    kind[2] = random_bit();
    // Half the draws become special values, sign kept from the word
    case (kind)
      3'd0: w[FP_W-2:0] = '0;
      3'd1: w[FP_W-2:0] = {{EXP_W{1'b1}}, {MAN_W{1'b0}}};
      3'd2: w[FP_W-2:MAN_W-1] = '1;
      3'd3: begin
        w[FP_W-2:MAN_W] = '1;
        w[MAN_W-1]      = 1'b0;
        w[0]            = 1'b1;
      end
      3'd4: begin
        w[FP_W-2:MAN_W] = '0;
        w[0]            = 1'b1;
      end
      default: ;
    endcase
    return w;
  endfunction

  // ----------------------------------------------------------------------
  // Reference model
  // ----------------------------------------------------------------------
  function automatic logic nan_of(fp_t x);
    return (x[MAN_W +: EXP_W] == '1) && (x[MAN_W-1:0] != '0);
  endfunction

  function automatic logic zero_of(fp_t x);
    return x[FP_W-2:0] == '0;
  endfunction

  // Monotonic unsigned key, negatives reversed below all positives
  function automatic fp_t order_key(fp_t x);
    if (x[FP_W-1]) return ~x;
    return {1'b1, x[FP_W-2:0]};
  endfunction

  // Bit position in the class table
  function automatic int class_index(fp_t x);
    logic s;
    s = x[FP_W-1];
    if (nan_of(x)) return x[MAN_W-1] ? 9 : 8;
    if (x[MAN_W +: EXP_W] == '1) return s ? 0 : 7;
    if (zero_of(x)) return s ? 3 : 4;
    if (x[MAN_W +: EXP_W] == '0) return s ? 2 : 5;
    return s ? 1 : 6;
  endfunction

  task automatic model_item(input fp_t a, input fp_t b, input op_t op, input rm_t rm,
                            input logic mod, output fp_t res, output status_t st,
                            output class_mask_t mask, output logic cls);
    logic a_nan, b_nan, any_snan, less, equal, flag;
    a_nan    = nan_of(a);
    b_nan    = nan_of(b);
    any_snan = (a_nan && !a[MAN_W-1]) || (b_nan && !b[MAN_W-1]);
    less     = order_key(a) < order_key(b);
    equal    = (a == b) || (zero_of(a) && zero_of(b));
    res      = '0;
    st       = '0;
    mask     = '0;
    cls      = 1'b0;
    flag     = 1'b0;
    case (op)
      OP_SGNJ: begin
        res = a;
        if (rm == RM_RNE) res[FP_W-1] = b[FP_W-1];
        else if (rm == RM_RTZ) res[FP_W-1] = ~b[FP_W-1];
        else if (rm == RM_RDN) res[FP_W-1] = a[FP_W-1] ^ b[FP_W-1];
      end
      OP_MINMAX: begin
        st[STATUS_NV] = any_snan;
        if (a_nan && b_nan) res = 32'h7fc0_0000;
        else if (a_nan) res = b;
        else if (b_nan) res = a;
        else if (rm == RM_RTZ) res = less ? b : a;
        else res = less ? a : b;
      end
      OP_CMP: begin
        if (any_snan) begin
          st[STATUS_NV] = 1'b1;
        end else if ((a_nan || b_nan) && rm == RM_RDN) begin
          res[0] = mod;
        end else if (a_nan || b_nan) begin
          st[STATUS_NV] = 1'b1;
        end else begin
          if (rm == RM_RNE) flag = less || equal;
          else if (rm == RM_RTZ) flag = less && !equal;
          else flag = equal;
          res[0] = flag ^ mod;
        end
      end
      default: begin
        cls                 = 1'b1;
        mask[class_index(a)] = 1'b1;
      end
    endcase
  endtask

  // ----------------------------------------------------------------------
  // Driving and collecting
  // ----------------------------------------------------------------------
  // Next falling edge, output ready follows the current mode
  task automatic tick();
    @(negedge clk_i);
    out_ready_i = bp_mode ? random_bit() : ready_level;
  endtask

  task automatic send_item(input fp_t a, input fp_t b, input op_t op, input rm_t rm,
                           input logic mod);
    fp_t         e_res;
    status_t     e_st;
    class_mask_t e_mask;
    logic        e_cls;
    model_item(a, b, op, rm, mod, e_res, e_st, e_mask, e_cls);
    tick();
    operand_a_i = a;
    operand_b_i = b;
    op_i        = op;
    rm_i        = rm;
    op_mod_i    = mod;
    tag_i       = next_tag;
    in_valid_i  = 1'b1;
    exp_tag_q.push_back(next_tag);
    exp_result_q.push_back(e_res);
    exp_status_q.push_back(e_st);
    exp_mask_q.push_back(e_mask);
    exp_class_q.push_back(e_cls);
    // Hold the item until the coming edge takes it
    #1;
    if (!busy_o) begin
      $display("ERR %0t: busy_o low while an item is offered", $time);
      error_count++;
    end
    while (!in_ready_o) begin
      tick();
      #1;
    end
    next_tag = next_tag + 1'b1;
    items_sent++;
  endtask

  // Stop sending and wait for every expected item
  task automatic drain();
    tick();
    in_valid_i = 1'b0;
    while (exp_tag_q.size() != 0) begin
      tick();
    end
    #1;
    if (busy_o) begin
      $display("ERR %0t: busy_o still high after all items left", $time);
      error_count++;
    end
  endtask

  task automatic check_output();
    tag_t        e_tag;
    fp_t         e_res;
    status_t     e_st;
    class_mask_t e_mask;
    logic        e_cls;
    if (exp_tag_q.size() == 0) begin
      $display("ERR %0t: unexpected output with tag %0h", $time, tag_o);
      error_count++;
    end else begin
      e_tag  = exp_tag_q.pop_front();
      e_res  = exp_result_q.pop_front();
      e_st   = exp_status_q.pop_front();
      e_mask = exp_mask_q.pop_front();
      e_cls  = exp_class_q.pop_front();
      if (tag_o !== e_tag || result_o !== e_res || status_o !== e_st ||
          is_class_o !== e_cls || (e_cls && class_mask_o !== e_mask)) begin
        $display("ERR %0t: tag %0h result %h status %b mask %b class %b", $time,
                 tag_o, result_o, status_o, class_mask_o, is_class_o);
        $display("ERR %0t: expected tag %0h result %h status %b mask %b class %b",
                 $time, e_tag, e_res, e_st, e_mask, e_cls);
        error_count++;
      end
      items_checked++;
    end
  endtask

  // Outputs settle after the falling edge and hold until the rising one
  always begin
    @(negedge clk_i);
    #1;
    if (out_valid_o && out_ready_i) check_output();
  end

  task automatic end_test(input string name);
    tests_run++;
    if (error_count != test_err_start) tests_failed++;
    $display("%s finished, %0d errors", name, error_count - test_err_start);
    test_err_start = error_count;
  endtask

  // ----------------------------------------------------------------------
  // Directed tests
  // ----------------------------------------------------------------------
  task automatic test_sign_injection();
    fp_t a, b;
    for (int i = 0; i < 40; i++) begin
      a = random_operand();
      b = random_operand();
      send_item(a, b, OP_SGNJ, rm_t'(i % 4), 1'b0);
    end
    drain();
    end_test("sign injection");
  endtask

  task automatic test_min_max();
    fp_t a, b;
    rm_t rm;
    // Signed zeros order -0 below +0
    send_item(32'h0000_0000, 32'h8000_0000, OP_MINMAX, RM_RNE, 1'b0);
    send_item(32'h0000_0000, 32'h8000_0000, OP_MINMAX, RM_RTZ, 1'b0);
    send_item(32'h8000_0000, 32'h0000_0000, OP_MINMAX, RM_RNE, 1'b0);
    for (int i = 0; i < 40; i++) begin
      a  = random_operand();
      b  = random_operand();
      rm = random_bit() ? RM_RTZ : RM_RNE;
      send_item(a, b, OP_MINMAX, rm, 1'b0);
    end
    drain();
    end_test("min max");
  endtask

  task automatic test_compare();
    fp_t        a, b;
    logic [1:0] sel;
    logic       mod;
    send_item(32'h0000_0000, 32'h8000_0000, OP_CMP, RM_RDN, 1'b0);
    send_item(32'h8000_0000, 32'h0000_0000, OP_CMP, RM_RTZ, 1'b0);
    send_item(32'h8000_0000, 32'h0000_0000, OP_CMP, RM_RNE, 1'b1);
    for (int i = 0; i < 48; i++) begin
      a      = random_operand();
      b      = random_operand();
      sel[0] = random_bit();
      sel[1] = random_bit();
      mod    = random_bit();
      // Every fourth pair compares a value with itself
      if (i % 4 == 0) b = a;
      send_item(a, b, OP_CMP, (sel == 2'd3) ? RM_RDN : rm_t'(sel), mod);
    end
    drain();
    end_test("compare");
  endtask

  task automatic test_classify();
    fp_t values [10] = '{32'hff80_0000, 32'hbf80_0000, 32'h8000_0001, 32'h8000_0000,
                         32'h0000_0000, 32'h0040_0000, 32'h4049_0fdb, 32'h7f80_0000,
                         32'h7f80_0001, 32'h7fc0_0000};
    for (int i = 0; i < 10; i++) begin
      send_item(values[i], '0, OP_CLASSIFY, RM_RNE, 1'b0);
    end
    drain();
    end_test("classify");
  endtask

  task automatic test_back_pressure();
    fp_t        a, b;
    logic [1:0] op_bits, rm_bits;
    rm_t        rm;
    bp_mode = 1'b1;
    for (int i = 0; i < 40; i++) begin
      a          = random_operand();
      b          = random_operand();
      op_bits[0] = random_bit();
      op_bits[1] = random_bit();
      rm_bits[0] = random_bit();
      rm_bits[1] = random_bit();
      case (op_t'(op_bits))
        OP_SGNJ: rm = rm_t'(rm_bits);
        OP_MINMAX: rm = rm_t'(rm_bits[0]);
        OP_CMP: rm = (rm_bits == 2'd3) ? RM_RDN : rm_t'(rm_bits);
        default: rm = RM_RNE;
      endcase
      send_item(a, b, op_t'(op_bits), rm, rm_bits[1]);
    end
    drain();
    bp_mode = 1'b0;
    end_test("back pressure");
  endtask

  task automatic test_flush();
    ready_level = 1'b0;
    for (int k = 0; k < NUM_STAGES; k++) begin
      send_item(random_operand(), 32'h0000_0000, OP_SGNJ, RM_RUP, 1'b0);
    end
    // Flush edge also carries a new item, which must vanish
    tick();
    flush_i     = 1'b1;
    operand_a_i = 32'h3f80_0000;
    op_i        = OP_SGNJ;
    rm_i        = RM_RUP;
    in_valid_i  = 1'b1;
    exp_tag_q.delete();
    exp_result_q.delete();
    exp_status_q.delete();
    exp_mask_q.delete();
    exp_class_q.delete();
    ready_level = 1'b1;
    tick();
    flush_i    = 1'b0;
    in_valid_i = 1'b0;
    repeat (NUM_STAGES + 3) tick();
    #1;
    if (busy_o || out_valid_o) begin
      $display("ERR %0t: busy_o %b out_valid_o %b after flush", $time, busy_o, out_valid_o);
      error_count++;
    end
    send_item(32'hc000_0000, 32'h0000_0000, OP_MINMAX, RM_RTZ, 1'b0);
    drain();
    end_test("flush");
  endtask

  // ----------------------------------------------------------------------
  // Main sequence and watchdog
  // ----------------------------------------------------------------------
  initial begin
    clk_i       = 1'b0;
    rst_i       = 1'b1;
    flush_i     = 1'b0;
    operand_a_i = '0;
    operand_b_i = '0;
    op_i        = OP_SGNJ;
    rm_i        = RM_RNE;
    op_mod_i    = 1'b0;
    tag_i       = '0;
    in_valid_i  = 1'b0;
    out_ready_i = 1'b1;
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;
    test_sign_injection();
    test_min_max();
    test_compare();
    test_classify();
    test_back_pressure();
    test_flush();
    $display("Tests run %0d, failed %0d, items sent %0d, checked %0d, errors %0d",
             tests_run, tests_failed, items_sent, items_checked, error_count);
    if (error_count == 0 && items_checked == items_sent - NUM_STAGES) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog expired, the run did not end within %0d cycles", WATCHDOG_CYCLES);
    $display("** FAIL **");
    $finish;
  end

endmodule

// File: fpnc.f
+incdir+.
fpnc_pkg.sv
fpnc_classifier.sv
fpnc_ops.sv
fpnc_pipe_stage.sv
fpnc_top.sv
fpnc_properties.sv
fpnc_tb.sv

// File: run.sh
#!/bin/sh
# Build the FPU testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module fpnc_tb -f fpnc.f -Mdir "$BUILD_DIR" -o fpnc_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/fpnc_sim" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q -x -F '** PASS **' "$LOG"; then
  echo "Simulation passed"
  exit 0
fi
echo "Simulation failed, see $LOG"
exit 1
